//--- hdl/nocPkg.sv
`default_nettype none

package nocPkg;

  typedef logic [2:0] flitIdT;
  typedef logic [31:0] payloadT;
  typedef logic [11:0] lengthT;

  // flit kinds are one-hot, so an all-zero id never matches any of them.
  localparam flitIdT FlitHead = 3'b001;
  localparam flitIdT FlitBody = 3'b010;
  localparam flitIdT FlitTail = 3'b100;

  // a head flit carries its tenure budget in the low payload bits.
  typedef struct packed {
    flitIdT  id;
    payloadT payload;
  } flitT;

endpackage

`default_nettype wire

//--- hdl/arbPkg.sv
`default_nettype none

package arbPkg;

  localparam int NumPorts = 5;

  // the declaration order is also the rotation order of the arbiter.
  typedef enum logic [2:0] {
    PortLocal,
    PortNorth,
    PortEast,
    PortWest,
    PortSouth
  } portT;

  // each owner state sits one code above its port.
  typedef enum logic [2:0] {
    StIdle,
    StLocal,
    StNorth,
    StEast,
    StWest,
    StSouth
  } arbStateT;

  typedef struct packed {
    nocPkg::flitT flit;
    portT         src;
  } taggedFlitT;

  typedef struct packed {
    logic [NumPorts-1:0] owner;
    logic                active;
  } grantT;

endpackage

`default_nettype wire

//--- hdl/inputFifo.sv
`default_nettype none

module inputFifo #(
  parameter int FifoDepth = 4
) (
  input  logic         clk,
  input  logic         rst,
  input  nocPkg::flitT inFlit,
  input  logic         inValid,
  output logic         inReady,
  input  logic         pop,
  output nocPkg::flitT headFlit,
  output logic         notEmpty
);
  import nocPkg::*;

  localparam int AddrW = $clog2(FifoDepth);

  flitT mem [FifoDepth];
  logic [AddrW:0] wrPtr;
  logic [AddrW:0] rdPtr;
  logic full;
  logic push;
  logic take;

  // the pointers carry one extra wrap bit so that full and empty can be told apart.
  assign notEmpty = wrPtr != rdPtr;
  assign full = (wrPtr[AddrW] != rdPtr[AddrW]) &&
                (wrPtr[AddrW-1:0] == rdPtr[AddrW-1:0]);
  assign inReady = !full;
  assign push = inValid && !full;
  assign take = pop && notEmpty;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= wrPtr + 1'b1;
      if (take)
        rdPtr <= rdPtr + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr[AddrW-1:0]] <= inFlit;
  end

  // an empty FIFO shows an all-zero head, so a stale entry is never taken for a head flit.
  assign headFlit = notEmpty ? mem[rdPtr[AddrW-1:0]] : '0;

endmodule

`default_nettype wire

//--- hdl/tenureTimer.sv
`default_nettype none

module tenureTimer (
  input  logic         clk,
  input  logic         rst,
  input  nocPkg::flitT headFlit,
  input  logic         runTimer,
  output logic         timesUp
);
  import nocPkg::*;

  lengthT budget;
  lengthT count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count <= '0;
    end
    else
    begin
      // the budget follows whichever head flit currently sits at the FIFO head.
      if (headFlit.id == FlitHead)
        budget <= headFlit.payload[$bits(lengthT)-1:0];
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = count == budget;

endmodule

`default_nettype wire

//--- hdl/tenureArbiter.sv
`default_nettype none

module tenureArbiter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [arbPkg::NumPorts-1:0] notEmpty,
  input  logic [arbPkg::NumPorts-1:0] timesUp,
  output logic [arbPkg::NumPorts-1:0] runTimer,
  output arbPkg::grantT               grant
);
  import arbPkg::*;

  arbStateT state;
  arbStateT stateNext;
  logic [2:0] ownerIdx;
  logic [NumPorts-1:0] ownerOneHot;
  logic keep;

  // returns the owner state of the first requesting port among span ports from start.
  function automatic arbStateT firstReady(
    input logic [NumPorts-1:0] req,
    input int unsigned         start,
    input int unsigned         span
  );
    arbStateT pick;
    int unsigned idx;
    int k;
    pick = StIdle;
    // walking backwards lets the port nearest to start win.
    for (k = int'(span) - 1; k >= 0; k--)
    begin
      idx = (start + k) % NumPorts;
      if (req[idx])
        pick = arbStateT'(3'(idx + 1));
    end
    return pick;
  endfunction

  assign ownerIdx = state - 3'd1;

  always_comb
  begin
    ownerOneHot = '0;
    keep = 1'b0;
    stateNext = StIdle;
    case (state)
      StIdle:
      begin
        stateNext = firstReady(notEmpty, 0, NumPorts);
      end
      StLocal, StNorth, StEast, StWest, StSouth:
      begin
        ownerOneHot[ownerIdx] = 1'b1;
        keep = notEmpty[ownerIdx] && !timesUp[ownerIdx];
        // a released owner is only picked again by way of idle.
        if (keep)
          stateNext = state;
        else
          stateNext = firstReady(notEmpty, ownerIdx + 1, NumPorts - 1);
      end
      default:
      begin
        stateNext = StIdle;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= StIdle;
    else
      state <= stateNext;
  end

  assign grant = '{owner: ownerOneHot, active: keep};
  assign runTimer = keep ? ownerOneHot : '0;

endmodule

`default_nettype wire

//--- hdl/flitSelect.sv
`default_nettype none

module flitSelect (
  input  arbPkg::grantT               grant,
  input  nocPkg::flitT                headFlit [arbPkg::NumPorts],
  input  logic                        outReady,
  output arbPkg::taggedFlitT          outFlit,
  output logic                        outValid,
  output logic [arbPkg::NumPorts-1:0] pop
);
  import arbPkg::*;

  always_comb
  begin
    int i;
    outFlit = '0;
    for (i = 0; i < NumPorts; i++)
    begin
      if (grant.owner[i])
      begin
        outFlit.flit = headFlit[i];
        outFlit.src = portT'(3'(i));
      end
    end
  end

  assign outValid = grant.active;

  // the owner's head leaves its FIFO only on a completed output transfer.
  assign pop = (grant.active && outReady) ? grant.owner : '0;

endmodule

`default_nettype wire

//--- hdl/outputStage.sv
`default_nettype none

module outputStage #(
  parameter int FifoDepth = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  nocPkg::flitT                inFlit [arbPkg::NumPorts],
  input  logic [arbPkg::NumPorts-1:0] inValid,
  output logic [arbPkg::NumPorts-1:0] inReady,
  output arbPkg::taggedFlitT          outFlit,
  output logic                        outValid,
  input  logic                        outReady
);
  import nocPkg::*;
  import arbPkg::*;

  flitT headFlit [NumPorts];
  logic [NumPorts-1:0] notEmpty;
  logic [NumPorts-1:0] timesUp;
  logic [NumPorts-1:0] runTimer;
  logic [NumPorts-1:0] pop;
  grantT grant;

  for (genvar p = 0; p < NumPorts; p++)
  begin : portSlice
    inputFifo #(
      .FifoDepth(FifoDepth)
    ) fifo_i (
      .clk     (clk),
      .rst     (rst),
      .inFlit  (inFlit[p]),
      .inValid (inValid[p]),
      .inReady (inReady[p]),
      .pop     (pop[p]),
      .headFlit(headFlit[p]),
      .notEmpty(notEmpty[p])
    );

    tenureTimer timer_i (
      .clk     (clk),
      .rst     (rst),
      .headFlit(headFlit[p]),
      .runTimer(runTimer[p]),
      .timesUp (timesUp[p])
    );
  end

  tenureArbiter arbiter_i (
    .clk     (clk),
    .rst     (rst),
    .notEmpty(notEmpty),
    .timesUp (timesUp),
    .runTimer(runTimer),
    .grant   (grant)
  );

  flitSelect select_i (
    .grant   (grant),
    .headFlit(headFlit),
    .outReady(outReady),
    .outFlit (outFlit),
    .outValid(outValid),
    .pop     (pop)
  );

endmodule

`default_nettype wire

//--- bench/outputChecker.sv
`default_nettype none

module outputChecker #(
  parameter int FifoDepth = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  nocPkg::flitT                inFlit [arbPkg::NumPorts],
  input  logic [arbPkg::NumPorts-1:0] inValid,
  input  logic [arbPkg::NumPorts-1:0] inReady,
  input  arbPkg::taggedFlitT          outFlit,
  input  logic                        outValid,
  input  logic                        outReady,
  output int                          errorCount,
  output int                          delivered
);
  import nocPkg::*;
  import arbPkg::*;

  flitT waiting [NumPorts][$];
  lengthT budget [NumPorts];
  logic [NumPorts-1:0] nonEmpty;
  logic [NumPorts-1:0] lastNonEmpty = '0;
  taggedFlitT lastFlit = '0;
  logic lastValid = 1'b0;
  logic lastReady = 1'b0;
  logic twoBackValid = 1'b0;
  portT lastSrc = PortLocal;
  int runLen = 0;
  int errors = 0;
  int transfers = 0;

  assign errorCount = errors;
  assign delivered = transfers;

  // first port holding a flit among span ports in rotation order from start, or -1.
  function automatic int scanFrom(
    input logic [NumPorts-1:0] ne,
    input int                  start,
    input int                  span
  );
    int k;
    for (k = 0; k < span; k++)
    begin
      if (ne[(start + k) % NumPorts])
        return (start + k) % NumPorts;
    end
    return -1;
  endfunction

  task automatic reportValue(input string sig, input logic [37:0] expected,
                             input logic [37:0] actual);
    errors++;
    $display("Error at %0t: %s expected %0h, got %0h", $time, sig, expected, actual);
  endtask

  task automatic reportProblem(input string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  // sampled at the falling edge, where every DUT input and output is settled.
  always @(negedge clk)
  begin
    int p;
    int expected;
    logic known;
    for (p = 0; p < NumPorts; p++)
    begin
      nonEmpty[p] = waiting[p].size() != 0;
      if (nonEmpty[p] && waiting[p][0].id == FlitHead)
        budget[p] = waiting[p][0].payload[$bits(lengthT)-1:0];
      if (!rst)
      begin
        assert (inReady[p] == (waiting[p].size() < FifoDepth))
        else reportValue("inReady", waiting[p].size() < FifoDepth, inReady[p]);
      end
    end
    if (rst || nonEmpty == '0)
    begin
      assert (!outValid) else reportValue("outValid", 0, outValid);
    end
    if (outValid)
    begin
      runLen = (lastValid && outFlit.src == lastSrc) ? runLen + 1 : 1;
      assert (runLen <= int'(budget[outFlit.src]))
      else reportProblem("tenure ran longer than its budget");
      if (!lastValid)
      begin
        // a single gap cycle means the owner handed over directly, a longer one means idle.
        expected = twoBackValid ? scanFrom(lastNonEmpty, int'(lastSrc) + 1, NumPorts - 1)
                                : scanFrom(lastNonEmpty, 0, NumPorts);
        assert (int'(outFlit.src) == expected)
        else reportValue("outFlit.src", expected, outFlit.src);
      end
      else
      begin
        assert (outFlit.src == lastSrc) else reportProblem("source changed without a gap");
      end
    end
    else if (lastValid && nonEmpty[lastSrc])
    begin
      assert (runLen == int'(budget[lastSrc]))
      else reportProblem("tenure released with flits left and budget unused");
    end
    if (lastValid && !lastReady && outValid)
    begin
      assert (outFlit == lastFlit) else reportValue("outFlit", lastFlit, outFlit);
    end
    if (outValid && outReady)
    begin
      known = int'(outFlit.src) < NumPorts && waiting[outFlit.src].size() != 0;
      assert (known) else reportProblem("output transfer with no matching input flit");
      if (known)
      begin
        assert (outFlit.flit == waiting[outFlit.src][0])
        else reportValue("outFlit.flit", waiting[outFlit.src][0], outFlit.flit);
        void'(waiting[outFlit.src].pop_front());
        transfers++;
      end
    end
    for (p = 0; p < NumPorts; p++)
    begin
      if (rst)
      begin
        waiting[p].delete();
        budget[p] = '0;
      end
      else if (inValid[p] && inReady[p])
        waiting[p].push_back(inFlit[p]);
    end
    if (outValid)
      lastSrc = outFlit.src;
    twoBackValid = lastValid;
    lastValid = outValid;
    lastReady = outReady;
    lastFlit = outFlit;
    lastNonEmpty = nonEmpty;
  end

endmodule

`default_nettype wire

//--- bench/outputStageTb.sv
`default_nettype none

module outputStageTb;
  import nocPkg::*;
  import arbPkg::*;

  localparam int ClkPeriod = 20;
  localparam int Drive = 2;
  localparam int Rounds = 4;
  localparam int PacketsPerRound = 2;
  localparam int NumPackets = Rounds * PacketsPerRound * NumPorts;

  logic clk;
  logic rst;
  flitT inFlit [NumPorts];
  logic [NumPorts-1:0] inValid;
  logic [NumPorts-1:0] inReady;
  taggedFlitT outFlit;
  logic outValid;
  logic outReady;
  int errorCount;
  int delivered;
  int sent = 0;
  logic timedOut = 1'b0;
  lengthT portBudget [NumPorts];
  logic [15:0] seqNum [NumPorts];

  outputStage #(
    .FifoDepth(4)
  ) dut_i (
    .clk     (clk),
    .rst     (rst),
    .inFlit  (inFlit),
    .inValid (inValid),
    .inReady (inReady),
    .outFlit (outFlit),
    .outValid(outValid),
    .outReady(outReady)
  );

  outputChecker #(
    .FifoDepth(4)
  ) checker_i (
    .clk       (clk),
    .rst       (rst),
    .inFlit    (inFlit),
    .inValid   (inValid),
    .inReady   (inReady),
    .outFlit   (outFlit),
    .outValid  (outValid),
    .outReady  (outReady),
    .errorCount(errorCount),
    .delivered (delivered)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic waitCycle();
    @(posedge clk);
    #Drive;
  endtask

  // the payload holds the port, a sequence number and, for a head flit, the budget.
  task automatic sendFlit(input int p, input flitIdT kind, input lengthT low);
    logic taken;
    inFlit[p] = '{id: kind, payload: {4'(p), seqNum[p], low}};
    inValid[p] = 1'b1;
    taken = 1'b0;
    while (!taken)
    begin
      @(negedge clk);
      taken = inReady[p];
      waitCycle();
    end
    inValid[p] = 1'b0;
    seqNum[p]++;
    sent++;
  endtask

  task automatic sendPackets(input int p);
    int n;
    int k;
    int bodies;
    for (n = 0; n < PacketsPerRound; n++)
    begin
      bodies = $urandom_range(0, 4);
      sendFlit(p, FlitHead, portBudget[p]);
      for (k = 0; k < bodies; k++)
        sendFlit(p, FlitBody, '0);
      sendFlit(p, FlitTail, '0);
      repeat ($urandom_range(0, 3)) waitCycle();
    end
  endtask

  task automatic reportAndFinish();
    $display("Checks failed: %0d, flits delivered: %0d of %0d", errorCount, delivered, sent);
    if (errorCount == 0 && delivered == sent && !timedOut)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  endtask

  initial
  begin
    int p;
    int r;
    void'($urandom(32'h7a85bd27));
    rst = 1'b1;
    inValid = '0;
    outReady = 1'b0;
    // the timer only stops on an exact match, so a budget that changed mid tenure
    // could be stepped over. each port keeps one budget for all its packets.
    for (p = 0; p < NumPorts; p++)
    begin
      inFlit[p] = '0;
      seqNum[p] = '0;
      portBudget[p] = lengthT'($urandom_range(1, 8));
    end
    repeat (10) @(posedge clk);
    #Drive;
    rst = 1'b0;
    for (r = 0; r < Rounds; r++)
    begin
      fork
        sendPackets(0);
        sendPackets(1);
        sendPackets(2);
        sendPackets(3);
        sendPackets(4);
      join
      // a quiet stretch lets every FIFO drain and the arbiter fall back to idle.
      repeat ($urandom_range(4, 16)) waitCycle();
    end
    while (delivered != sent)
      waitCycle();
    repeat (5) waitCycle();
    reportAndFinish();
  end

  initial
  begin
    forever
    begin
      waitCycle();
      outReady = !rst && ($urandom_range(0, 3) != 0);
    end
  end

  initial
  begin
    #(NumPackets * 40 * ClkPeriod);
    $display("Watchdog expired before all flits were delivered");
    timedOut = 1'b1;
    reportAndFinish();
  end

endmodule

`default_nettype wire

//--- flist.f
hdl/nocPkg.sv
hdl/arbPkg.sv
hdl/inputFifo.sv
hdl/tenureTimer.sv
hdl/tenureArbiter.sv
hdl/flitSelect.sv
hdl/outputStage.sv
bench/outputChecker.sv
bench/outputStageTb.sv

//--- Bender.yml
package:
  name: outputStage

sources:
  - hdl/nocPkg.sv
  - hdl/arbPkg.sv
  - hdl/inputFifo.sv
  - hdl/tenureTimer.sv
  - hdl/tenureArbiter.sv
  - hdl/flitSelect.sv
  - hdl/outputStage.sv
  - target: test
    files:
      - bench/outputChecker.sv
      - bench/outputStageTb.sv
